//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int bus_width = 64;
	localparam int strb_width = bus_width / 8;
	localparam int reg_addr_width = 5;
	localparam int span_width = 2 * strb_width;

	typedef enum logic [2:0] {
		op_lw = 3'd0,
		op_lh = 3'd1,
		op_lhu = 3'd2,
		op_lb = 3'd3,
		op_lbu = 3'd4,
		op_sw = 3'd5,
		op_sh = 3'd6,
		op_sb = 3'd7
	} mem_op_t;

	// byte address, or 64-bit word index plus lane
	typedef union packed {
		logic [addr_width-1:0] raw;
		struct packed {
			logic [addr_width-4:0] index;
			logic [2:0] offset;
		} part;
	} mem_addr_t;

	function automatic logic is_load(input mem_op_t op);
		return op inside {op_lw, op_lh, op_lhu, op_lb, op_lbu};
	endfunction

	function automatic logic [2:0] access_bytes(input mem_op_t op);
		case (op)
			op_lw, op_sw: return 3'd4;
			op_lh, op_lhu, op_sh: return 3'd2;
			default: return 3'd1;
		endcase
	endfunction

	// lanes of the access before the cut at the group edge
	function automatic logic [span_width-1:0] lane_span(
		input mem_op_t op,
		input logic [2:0] offset
	);
		logic [span_width-1:0] span;
		span = (span_width'(1) << access_bytes(op)) - span_width'(1);
		return span << offset;
	endfunction

	// lanes of the 4-byte group holding the offset
	function automatic logic [strb_width-1:0] group_mask(input logic [2:0] offset);
		return offset[2] ? 8'hf0 : 8'h0f;
	endfunction

	function automatic logic [strb_width-1:0] first_strobe(
		input mem_op_t op,
		input logic [2:0] offset
	);
		logic [span_width-1:0] span;
		span = lane_span(op, offset);
		return span[strb_width-1:0] & group_mask(offset);
	endfunction

	// spill past the group end, folded back into the next group's lanes
	function automatic logic [strb_width-1:0] second_strobe(
		input mem_op_t op,
		input logic [2:0] offset
	);
		logic [span_width-1:0] span;
		span = lane_span(op, offset);
		return (span[strb_width-1:0] & ~group_mask(offset)) | span[span_width-1:strb_width];
	endfunction

endpackage

`default_nettype wire

//--- rtl/beat_if.sv
`timescale 1ns/10ps
`default_nettype none

interface beat_if #(
	parameter int bus_width = mem_pkg::bus_width
);
	import mem_pkg::*;

	logic start;
	logic [addr_width-1:0] addr;
	// a beat with no write lanes set is a read
	logic [bus_width/8-1:0] strb;
	logic [bus_width-1:0] wdata;
	logic finished;
	logic [bus_width-1:0] rdata;

	// per engine completion, merged into finished above the engines
	logic rd_finished;
	logic wr_finished;

	modport planner (
		output start,
		output addr,
		output strb,
		output wdata,
		input finished,
		input rdata
	);

	modport reader (
		input start,
		input addr,
		input strb,
		output rd_finished,
		output rdata
	);

	modport writer (
		input start,
		input addr,
		input strb,
		input wdata,
		output wr_finished
	);

endinterface

`default_nettype wire

//--- rtl/access_planner.sv
`timescale 1ns/10ps
`default_nettype none

module access_planner #(
	parameter int data_width = mem_pkg::data_width,
	parameter int bus_width = 2 * data_width
) (
	input logic clock,
	input logic reset,
	input logic req_valid,
	input mem_pkg::mem_op_t req_op,
	input mem_pkg::mem_addr_t req_addr,
	input logic [data_width-1:0] req_wdata,
	input logic [mem_pkg::reg_addr_width-1:0] req_rd,
	beat_if.planner beat,
	output mem_pkg::mem_op_t op,
	output logic [2:0] offset,
	output logic [mem_pkg::reg_addr_width-1:0] rd_addr,
	output logic [bus_width-1:0] first_rdata,
	output logic done,
	output logic rd_wen
);
	import mem_pkg::*;

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_first = 2'd1;
	localparam logic [1:0] st_second = 2'd2;

	logic [1:0] state;
	mem_addr_t addr_q;
	logic [data_width-1:0] wdata_q;
	mem_addr_t first_addr;
	mem_addr_t second_addr;
	logic [strb_width-1:0] first_strb;
	logic [strb_width-1:0] second_strb;
	logic split;
	logic [bus_width-1:0] lane_word;
	logic [2*bus_width-1:0] lane_wide;

	// ------------------------------
	// request and first beat data
	always_ff @(posedge clock) begin
		if (state == st_idle && req_valid) begin
			op <= req_op;
			addr_q <= req_addr;
			wdata_q <= req_wdata;
			rd_addr <= req_rd;
		end
		if (state == st_first && beat.finished) begin
			first_rdata <= beat.rdata;
		end
	end

	assign offset = addr_q.part.offset;
	assign first_strb = first_strobe(op, offset);
	assign second_strb = second_strobe(op, offset);
	assign split = (second_strb != '0);

	always_comb begin
		first_addr = addr_q;
		first_addr.part.offset = 3'd0;
		second_addr = first_addr;
		// upper group spills into the next 64-bit word
		if (offset[2]) begin
			second_addr.part.index = first_addr.part.index + {{(addr_width-4){1'b0}}, 1'b1};
		end
	end

	// store word rotated into its lanes, same layout for both beats
	assign lane_word = {{(bus_width-data_width){1'b0}}, wdata_q};
	assign lane_wide = {lane_word, lane_word} << {offset, 3'b000};

	always_comb begin
		beat.addr = (state == st_second) ? second_addr.raw : first_addr.raw;
		beat.wdata = lane_wide[2*bus_width-1:bus_width];
		beat.strb = '0;
		if (!is_load(op)) begin
			beat.strb = (state == st_second) ? second_strb : first_strb;
		end
	end

	// ------------------------------
	// beat sequencing
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			beat.start <= 1'b0;
			done <= 1'b0;
			rd_wen <= 1'b0;
		end else begin
			beat.start <= 1'b0;
			done <= 1'b0;
			rd_wen <= 1'b0;
			case (state)
				st_idle: begin
					// strobes while busy fall through here unseen
					if (req_valid) begin
						beat.start <= 1'b1;
						state <= st_first;
					end
				end
				st_first: begin
					if (beat.finished) begin
						if (split) begin
							beat.start <= 1'b1;
							state <= st_second;
						end else begin
							done <= 1'b1;
							rd_wen <= is_load(op);
							state <= st_idle;
						end
					end
				end
				default: begin
					if (beat.finished) begin
						done <= 1'b1;
						rd_wen <= is_load(op);
						state <= st_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/read_engine.sv
`timescale 1ns/10ps
`default_nettype none

module read_engine #(
	parameter int data_width = mem_pkg::data_width,
	parameter int bus_width = 2 * data_width
) (
	input logic clock,
	input logic reset,
	beat_if.reader beat,
	output logic ar_valid,
	output logic [mem_pkg::addr_width-1:0] ar_addr,
	input logic ar_ready,
	output logic r_ready,
	input logic r_valid,
	input logic [bus_width-1:0] r_data
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_address = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_finish = 2'd3;

	logic [1:0] state;
	logic read_start;

	// reads carry no write lanes
	assign read_start = beat.start && (beat.strb == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (read_start) begin
						state <= st_address;
					end
				end
				st_address: begin
					if (ar_ready) begin
						state <= st_data;
					end
				end
				st_data: begin
					if (r_valid) begin
						state <= st_finish;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// beat payload
	always_ff @(posedge clock) begin
		if (state == st_idle && read_start) begin
			ar_addr <= beat.addr;
		end
		if (r_valid && r_ready) begin
			beat.rdata <= r_data;
		end
	end

	assign ar_valid = (state == st_address);
	assign r_ready = (state == st_data);
	assign beat.rd_finished = (state == st_finish);

endmodule

`default_nettype wire

//--- rtl/write_engine.sv
`timescale 1ns/10ps
`default_nettype none

module write_engine #(
	parameter int data_width = mem_pkg::data_width,
	parameter int bus_width = 2 * data_width
) (
	input logic clock,
	input logic reset,
	beat_if.writer beat,
	output logic aw_valid,
	output logic [mem_pkg::addr_width-1:0] aw_addr,
	input logic aw_ready,
	output logic w_valid,
	output logic [bus_width-1:0] w_data,
	output logic [bus_width/8-1:0] w_strb,
	input logic w_ready,
	output logic b_ready,
	input logic b_valid
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_send = 2'd1;
	localparam logic [1:0] st_resp = 2'd2;
	localparam logic [1:0] st_finish = 2'd3;

	logic [1:0] state;
	logic write_start;
	logic aw_pending;
	logic w_pending;

	assign write_start = beat.start && (beat.strb != '0);

	// still waiting after this cycle
	assign aw_pending = aw_valid && !aw_ready;
	assign w_pending = w_valid && !w_ready;

	// ------------------------------
	// address and data run independently
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			aw_valid <= 1'b0;
			w_valid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (write_start) begin
						aw_valid <= 1'b1;
						w_valid <= 1'b1;
						state <= st_send;
					end
				end
				st_send: begin
					aw_valid <= aw_pending;
					w_valid <= w_pending;
					if (!aw_pending && !w_pending) begin
						state <= st_resp;
					end
				end
				st_resp: begin
					if (b_valid) begin
						state <= st_finish;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == st_idle && write_start) begin
			aw_addr <= beat.addr;
			w_data <= beat.wdata;
			w_strb <= beat.strb;
		end
	end

	// response accepted only once both channels are through
	assign b_ready = (state == st_resp);
	assign beat.wr_finished = (state == st_finish);

endmodule

`default_nettype wire

//--- rtl/load_merge.sv
`timescale 1ns/10ps
`default_nettype none

module load_merge #(
	parameter int data_width = mem_pkg::data_width,
	parameter int bus_width = 2 * data_width
) (
	input mem_pkg::mem_op_t op,
	input logic [2:0] offset,
	input logic [bus_width-1:0] first_rdata,
	input logic [bus_width-1:0] last_rdata,
	output logic [data_width-1:0] rd_data
);
	import mem_pkg::*;

	logic [strb_width-1:0] first_strb;
	logic [strb_width-1:0] second_strb;
	logic [bus_width-1:0] merged;
	logic [2*bus_width-1:0] wide;
	logic [data_width-1:0] aligned;

	assign first_strb = first_strobe(op, offset);
	assign second_strb = second_strobe(op, offset);

	// ------------------------------
	// lane gather, each lane from at most one beat
	always_comb begin
		for (int i = 0; i < strb_width; i++) begin
			if (first_strb[i]) begin
				merged[8*i +: 8] = first_rdata[8*i +: 8];
			end else if (second_strb[i]) begin
				merged[8*i +: 8] = last_rdata[8*i +: 8];
			end else begin
				merged[8*i +: 8] = 8'h00;
			end
		end
	end

	// rotate so the lowest accessed byte lands in bit 0
	assign wide = {merged, merged} >> {offset, 3'b000};
	assign aligned = wide[data_width-1:0];

	// ------------------------------
	// sign or zero extension
	always_comb begin
		case (op)
			op_lh: begin
				rd_data = {{(data_width-16){aligned[15]}}, aligned[15:0]};
			end
			op_lhu: begin
				rd_data = {{(data_width-16){1'b0}}, aligned[15:0]};
			end
			op_lb: begin
				rd_data = {{(data_width-8){aligned[7]}}, aligned[7:0]};
			end
			op_lbu: begin
				rd_data = {{(data_width-8){1'b0}}, aligned[7:0]};
			end
			default: begin
				rd_data = aligned;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage #(
	parameter int data_width = mem_pkg::data_width,
	parameter int bus_width = mem_pkg::bus_width
) (
	input logic clock,
	input logic reset,
	// request
	input logic req_valid,
	input mem_pkg::mem_op_t req_op,
	input logic [mem_pkg::addr_width-1:0] req_addr,
	input logic [data_width-1:0] req_wdata,
	input logic [mem_pkg::reg_addr_width-1:0] req_rd,
	// response
	output logic done,
	output logic rd_wen,
	output logic [mem_pkg::reg_addr_width-1:0] rd_addr,
	output logic [data_width-1:0] rd_data,
	// read channels
	output logic ar_valid,
	output logic [mem_pkg::addr_width-1:0] ar_addr,
	input logic ar_ready,
	output logic r_ready,
	input logic r_valid,
	input logic [bus_width-1:0] r_data,
	// write channels
	output logic aw_valid,
	output logic [mem_pkg::addr_width-1:0] aw_addr,
	input logic aw_ready,
	output logic w_valid,
	output logic [bus_width-1:0] w_data,
	output logic [bus_width/8-1:0] w_strb,
	input logic w_ready,
	output logic b_ready,
	input logic b_valid
);
	import mem_pkg::*;

	mem_op_t op;
	logic [2:0] offset;
	logic [bus_width-1:0] first_rdata;

	beat_if #(.bus_width(bus_width)) beat ();

	// only one engine is ever busy
	assign beat.finished = beat.rd_finished | beat.wr_finished;

	access_planner #(
		.data_width(data_width),
		.bus_width(bus_width)
	) access_planner_inst (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_rd(req_rd),
		.beat(beat.planner),
		.op(op),
		.offset(offset),
		.rd_addr(rd_addr),
		.first_rdata(first_rdata),
		.done(done),
		.rd_wen(rd_wen)
	);

	read_engine #(
		.data_width(data_width),
		.bus_width(bus_width)
	) read_engine_inst (
		.clock(clock),
		.reset(reset),
		.beat(beat.reader),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.ar_ready(ar_ready),
		.r_ready(r_ready),
		.r_valid(r_valid),
		.r_data(r_data)
	);

	write_engine #(
		.data_width(data_width),
		.bus_width(bus_width)
	) write_engine_inst (
		.clock(clock),
		.reset(reset),
		.beat(beat.writer),
		.aw_valid(aw_valid),
		.aw_addr(aw_addr),
		.aw_ready(aw_ready),
		.w_valid(w_valid),
		.w_data(w_data),
		.w_strb(w_strb),
		.w_ready(w_ready),
		.b_ready(b_ready),
		.b_valid(b_valid)
	);

	// last beat data is still held in the read engine at done
	load_merge #(
		.data_width(data_width),
		.bus_width(bus_width)
	) load_merge_inst (
		.op(op),
		.offset(offset),
		.first_rdata(first_rdata),
		.last_rdata(beat.rdata),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

//--- dv/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model #(
	parameter int seed = 22
) (
	input logic clock,
	input logic reset,
	input logic ar_valid,
	input logic [mem_pkg::addr_width-1:0] ar_addr,
	output logic ar_ready,
	input logic r_ready,
	output logic r_valid,
	output logic [mem_pkg::bus_width-1:0] r_data,
	input logic aw_valid,
	input logic [mem_pkg::addr_width-1:0] aw_addr,
	output logic aw_ready,
	input logic w_valid,
	input logic [mem_pkg::bus_width-1:0] w_data,
	input logic [mem_pkg::strb_width-1:0] w_strb,
	output logic w_ready,
	input logic b_ready,
	output logic b_valid
);
	import mem_pkg::*;

	logic [7:0] mem [0:255];
	int ar_count;
	int aw_count;
	int w_count;
	logic [strb_width-1:0] last_strb;
	int ar_wait;
	int aw_wait;
	int w_wait;
	logic aw_seen;
	logic w_seen;
	logic seeded;

	initial begin
		// every byte differs from its neighbors
		for (int a = 0; a < 256; a++) begin
			mem[a] = 8'(a) ^ 8'ha5;
		end
		ar_count = 0;
		aw_count = 0;
		w_count = 0;
		last_strb = '0;
		ar_wait = 0;
		aw_wait = 0;
		w_wait = 0;
		aw_seen = 1'b0;
		w_seen = 1'b0;
		seeded = 1'b0;
		ar_ready = 1'b0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		b_valid = 1'b0;
	end

	always @(posedge clock) begin
		logic ar_fire;
		logic r_fire;
		logic aw_fire;
		logic w_fire;
		logic b_fire;
		logic [7:0] base;
		// handshakes as the DUT sees them at this edge
		ar_fire = ar_valid && ar_ready;
		r_fire = r_valid && r_ready;
		aw_fire = aw_valid && aw_ready;
		w_fire = w_valid && w_ready;
		b_fire = b_valid && b_ready;
		#1;
		if (!seeded) begin
			void'($urandom(seed));
			seeded = 1'b1;
		end
		if (reset) begin
			ar_wait = 0;
			aw_wait = 0;
			w_wait = 0;
			aw_seen = 1'b0;
			w_seen = 1'b0;
			r_valid = 1'b0;
			b_valid = 1'b0;
		end else begin
			// ------------------------------
			// read side
			if (r_fire) begin
				r_valid = 1'b0;
			end
			if (ar_fire) begin
				base = {ar_addr[7:3], 3'b000};
				for (int i = 0; i < strb_width; i++) begin
					r_data[8*i +: 8] = mem[base + 8'(i)];
				end
				r_valid = 1'b1;
				ar_count++;
				ar_wait = int'($urandom % 4);
			end else if (ar_valid && ar_wait > 0) begin
				ar_wait--;
			end
			// ------------------------------
			// write side, address and data in any order
			if (b_fire) begin
				b_valid = 1'b0;
			end
			if (aw_fire) begin
				aw_seen = 1'b1;
				aw_count++;
				aw_wait = int'($urandom % 4);
			end else if (aw_valid && aw_wait > 0) begin
				aw_wait--;
			end
			if (w_fire) begin
				w_seen = 1'b1;
				w_count++;
				last_strb = w_strb;
				w_wait = int'($urandom % 4);
			end else if (w_valid && w_wait > 0) begin
				w_wait--;
			end
			if (aw_seen && w_seen) begin
				base = {aw_addr[7:3], 3'b000};
				for (int i = 0; i < strb_width; i++) begin
					if (w_strb[i]) begin
						mem[base + 8'(i)] = w_data[8*i +: 8];
					end
				end
				aw_seen = 1'b0;
				w_seen = 1'b0;
				b_valid = 1'b1;
			end
		end
		ar_ready = (ar_wait == 0);
		aw_ready = (aw_wait == 0);
		w_ready = (w_wait == 0);
	end

endmodule

`default_nettype wire

//--- dv/mem_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb;
	import mem_pkg::*;

	localparam int done_limit = 200;
	localparam int random_seed = 22;

	logic clock;
	logic reset;
	logic req_valid;
	mem_op_t req_op;
	logic [addr_width-1:0] req_addr;
	logic [data_width-1:0] req_wdata;
	logic [reg_addr_width-1:0] req_rd;
	logic done;
	logic rd_wen;
	logic [reg_addr_width-1:0] rd_addr;
	logic [data_width-1:0] rd_data;
	logic ar_valid;
	logic [addr_width-1:0] ar_addr;
	logic ar_ready;
	logic r_ready;
	logic r_valid;
	logic [bus_width-1:0] r_data;
	logic aw_valid;
	logic [addr_width-1:0] aw_addr;
	logic aw_ready;
	logic w_valid;
	logic [bus_width-1:0] w_data;
	logic [strb_width-1:0] w_strb;
	logic w_ready;
	logic b_ready;
	logic b_valid;

	// table columns, one entry per test
	string row_name [$];
	mem_op_t row_op [$];
	logic [addr_width-1:0] row_addr [$];
	logic [data_width-1:0] row_wdata [$];
	logic row_wen [$];
	logic [data_width-1:0] row_data [$];
	int row_aw [$];
	int row_ar [$];
	logic [strb_width-1:0] row_strb [$];
	logic row_poke [$];

	int mismatches;
	int failing_tests;
	logic timed_out;

	initial clock = 1'b0;
	always #5 clock = ~clock;

	mem_stage #(
		.data_width(data_width),
		.bus_width(bus_width)
	) mem_stage_inst (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_rd(req_rd),
		.done(done),
		.rd_wen(rd_wen),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.ar_ready(ar_ready),
		.r_ready(r_ready),
		.r_valid(r_valid),
		.r_data(r_data),
		.aw_valid(aw_valid),
		.aw_addr(aw_addr),
		.aw_ready(aw_ready),
		.w_valid(w_valid),
		.w_data(w_data),
		.w_strb(w_strb),
		.w_ready(w_ready),
		.b_ready(b_ready),
		.b_valid(b_valid)
	);

	axi_mem_model #(.seed(random_seed)) mem_model (
		.clock(clock),
		.reset(reset),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.ar_ready(ar_ready),
		.r_ready(r_ready),
		.r_valid(r_valid),
		.r_data(r_data),
		.aw_valid(aw_valid),
		.aw_addr(aw_addr),
		.aw_ready(aw_ready),
		.w_valid(w_valid),
		.w_data(w_data),
		.w_strb(w_strb),
		.w_ready(w_ready),
		.b_ready(b_ready),
		.b_valid(b_valid)
	);

	task automatic add_row(
		input string name,
		input mem_op_t op,
		input logic [31:0] addr,
		input logic [31:0] wdata,
		input logic wen,
		input logic [31:0] data,
		input int aw,
		input int ar,
		input logic [7:0] strb,
		input logic poke
	);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_wdata.push_back(wdata);
		row_wen.push_back(wen);
		row_data.push_back(data);
		row_aw.push_back(aw);
		row_ar.push_back(ar);
		row_strb.push_back(strb);
		row_poke.push_back(poke);
	endtask

	// ------------------------------
	// name, op, addr, store data, wen, load result, aw beats, ar beats, last strobe, busy strobe
	task automatic build_table();
		add_row("t1_sw_aligned", op_sw, 32'h00, 32'h1234_5678, 1'b0, 32'h0, 1, 0, 8'h0f, 1'b0);
		add_row("t1_lw_aligned", op_lw, 32'h00, 32'h0, 1'b1, 32'h1234_5678, 0, 1, 8'h00, 1'b0);
		add_row("t2_sw_off1", op_sw, 32'h09, 32'ha1b2_c3d4, 1'b0, 32'h0, 2, 0, 8'h10, 1'b0);
		add_row("t2_lw_off1", op_lw, 32'h09, 32'h0, 1'b1, 32'ha1b2_c3d4, 0, 2, 8'h00, 1'b0);
		add_row("t2_sw_off2", op_sw, 32'h12, 32'h5566_7788, 1'b0, 32'h0, 2, 0, 8'h30, 1'b0);
		add_row("t2_lw_off2", op_lw, 32'h12, 32'h0, 1'b1, 32'h5566_7788, 0, 2, 8'h00, 1'b0);
		add_row("t2_sw_off3", op_sw, 32'h1b, 32'h0f1e_2d3c, 1'b0, 32'h0, 2, 0, 8'h70, 1'b0);
		add_row("t2_lw_off3", op_lw, 32'h1b, 32'h0, 1'b1, 32'h0f1e_2d3c, 0, 2, 8'h00, 1'b0);
		add_row("t2_sw_off5", op_sw, 32'h25, 32'h9988_7766, 1'b0, 32'h0, 2, 0, 8'h01, 1'b0);
		add_row("t2_lw_off5", op_lw, 32'h25, 32'h0, 1'b1, 32'h9988_7766, 0, 2, 8'h00, 1'b0);
		add_row("t2_sw_off6", op_sw, 32'h2e, 32'h1357_9bdf, 1'b0, 32'h0, 2, 0, 8'h03, 1'b0);
		add_row("t2_lw_off6", op_lw, 32'h2e, 32'h0, 1'b1, 32'h1357_9bdf, 0, 2, 8'h00, 1'b0);
		add_row("t2_sw_off0", op_sw, 32'h30, 32'h2468_ace0, 1'b0, 32'h0, 1, 0, 8'h0f, 1'b0);
		add_row("t2_lw_off0", op_lw, 32'h30, 32'h0, 1'b1, 32'h2468_ace0, 0, 1, 8'h00, 1'b0);
		add_row("t2_sw_off4", op_sw, 32'h3c, 32'hfedc_ba98, 1'b0, 32'h0, 1, 0, 8'hf0, 1'b0);
		add_row("t2_lw_off4", op_lw, 32'h3c, 32'h0, 1'b1, 32'hfedc_ba98, 0, 1, 8'h00, 1'b0);
		// half at 0x53 straddles the group edge, bit 15 set
		add_row("t3_sw_low", op_sw, 32'h50, 32'hc700_0000, 1'b0, 32'h0, 1, 0, 8'h0f, 1'b0);
		add_row("t3_sw_high", op_sw, 32'h54, 32'h0000_00f1, 1'b0, 32'h0, 1, 0, 8'hf0, 1'b0);
		add_row("t3_lh_off3", op_lh, 32'h53, 32'h0, 1'b1, 32'hffff_f1c7, 0, 2, 8'h00, 1'b0);
		add_row("t3_lhu_off3", op_lhu, 32'h53, 32'h0, 1'b1, 32'h0000_f1c7, 0, 2, 8'h00, 1'b0);
		add_row("t3_sh_off3", op_sh, 32'h53, 32'h1234_8a5b, 1'b0, 32'h0, 2, 0, 8'h10, 1'b0);
		add_row("t3_lb_hi", op_lb, 32'h54, 32'h0, 1'b1, 32'hffff_ff8a, 0, 1, 8'h00, 1'b0);
		add_row("t3_lbu_lo", op_lbu, 32'h53, 32'h0, 1'b1, 32'h0000_005b, 0, 1, 8'h00, 1'b0);
		add_row("t3_lw_after", op_lw, 32'h54, 32'h0, 1'b1, 32'h0000_008a, 0, 1, 8'h00, 1'b0);
		// byte stores downward, other lanes carry junk
		add_row("t4_clear_lo", op_sw, 32'h40, 32'h0, 1'b0, 32'h0, 1, 0, 8'h0f, 1'b0);
		add_row("t4_clear_hi", op_sw, 32'h44, 32'h0, 1'b0, 32'h0, 1, 0, 8'hf0, 1'b0);
		add_row("t4_sb_off7", op_sb, 32'h47, 32'heedd_cca7, 1'b0, 32'h0, 1, 0, 8'h80, 1'b0);
		add_row("t4_sb_off6", op_sb, 32'h46, 32'heedd_cca6, 1'b0, 32'h0, 1, 0, 8'h40, 1'b0);
		add_row("t4_sb_off5", op_sb, 32'h45, 32'heedd_cca5, 1'b0, 32'h0, 1, 0, 8'h20, 1'b0);
		add_row("t4_sb_off4", op_sb, 32'h44, 32'heedd_cca4, 1'b0, 32'h0, 1, 0, 8'h10, 1'b0);
		add_row("t4_sb_off3", op_sb, 32'h43, 32'heedd_cca3, 1'b0, 32'h0, 1, 0, 8'h08, 1'b0);
		add_row("t4_sb_off2", op_sb, 32'h42, 32'heedd_cca2, 1'b0, 32'h0, 1, 0, 8'h04, 1'b0);
		add_row("t4_sb_off1", op_sb, 32'h41, 32'heedd_cca1, 1'b0, 32'h0, 1, 0, 8'h02, 1'b0);
		add_row("t4_sb_off0", op_sb, 32'h40, 32'heedd_cca0, 1'b0, 32'h0, 1, 0, 8'h01, 1'b0);
		add_row("t4_lw_lo", op_lw, 32'h40, 32'h0, 1'b1, 32'ha3a2_a1a0, 0, 1, 8'h00, 1'b0);
		add_row("t4_lw_hi", op_lw, 32'h44, 32'h0, 1'b1, 32'ha7a6_a5a4, 0, 1, 8'h00, 1'b0);
		// busy strobes target 0x68, which must keep its fill
		add_row("t5_sw_busy", op_sw, 32'h60, 32'h0bad_f00d, 1'b0, 32'h0, 1, 0, 8'h0f, 1'b1);
		add_row("t5_lw_busy", op_lw, 32'h60, 32'h0, 1'b1, 32'h0bad_f00d, 0, 1, 8'h00, 1'b1);
		add_row("t5_lw_fill", op_lw, 32'h68, 32'h0, 1'b1, 32'hcecf_cccd, 0, 1, 8'h00, 1'b0);
	endtask

	task automatic compare_value(
		input string test,
		input string what,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (actual !== expected) begin
			$display("Error %s %s: expected %h, actual %h", test, what, expected, actual);
			mismatches++;
		end
	endtask

	// ------------------------------
	// one access, start to done
	task automatic run_row(input int i);
		int aw_before;
		int w_before;
		int ar_before;
		int errors_before;
		int cycles;
		aw_before = mem_model.aw_count;
		w_before = mem_model.w_count;
		ar_before = mem_model.ar_count;
		errors_before = mismatches;
		req_valid = 1'b1;
		req_op = row_op[i];
		req_addr = row_addr[i];
		req_wdata = row_wdata[i];
		req_rd = 5'(i + 1);
		@(posedge clock);
		#1;
		req_valid = 1'b0;
		if (row_poke[i]) begin
			req_valid = 1'b1;
			req_op = op_sw;
			req_addr = 32'h68;
			req_wdata = 32'hdead_beef;
			req_rd = 5'd31;
			@(posedge clock);
			#1;
			req_valid = 1'b0;
		end
		cycles = 0;
		while (!done && cycles < done_limit) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!done) begin
			$display("test %s: no done within %0d cycles", row_name[i], done_limit);
			timed_out = 1'b1;
			failing_tests++;
		end else begin
			compare_value(row_name[i], "rd_wen", 32'(row_wen[i]), 32'(rd_wen));
			compare_value(row_name[i], "rd_addr", 32'(i + 1) & 32'h1f, 32'(rd_addr));
			if (row_wen[i]) begin
				compare_value(row_name[i], "rd_data", row_data[i], rd_data);
			end
			compare_value(row_name[i], "aw beats", row_aw[i], mem_model.aw_count - aw_before);
			compare_value(row_name[i], "w beats", row_aw[i], mem_model.w_count - w_before);
			compare_value(row_name[i], "ar beats", row_ar[i], mem_model.ar_count - ar_before);
			if (row_aw[i] > 0) begin
				compare_value(row_name[i], "w_strb", 32'(row_strb[i]), 32'(mem_model.last_strb));
			end
			if (mismatches == errors_before) begin
				$display("test %s: ok", row_name[i]);
			end else begin
				$display("test %s: %0d mismatches", row_name[i], mismatches - errors_before);
				failing_tests++;
			end
		end
	endtask

	initial begin
		mismatches = 0;
		failing_tests = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = op_lw;
		req_addr = '0;
		req_wdata = '0;
		req_rd = '0;
		build_table();
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		@(posedge clock);
		#1;
		for (int i = 0; i < row_name.size() && !timed_out; i++) begin
			run_row(i);
		end
		$display("tests %0d, failing %0d, mismatches %0d", row_name.size(), failing_tests,
			mismatches);
		if (!timed_out && mismatches == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mem_stage.f
rtl/mem_pkg.sv
rtl/beat_if.sv
rtl/access_planner.sv
rtl/read_engine.sv
rtl/write_engine.sv
rtl/load_merge.sv
rtl/mem_stage.sv
dv/axi_mem_model.sv
dv/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mem_stage_tb
FILELIST ?= mem_stage.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/10ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
